/* src/fetch_pkg.sv */
package fetch_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;
  localparam logic [xlen-1:0] nop = 32'h0000_0013; // addi x0,x0,0.

  typedef enum logic [6:0] {
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_load   = 7'b0000011,
    opc_store  = 7'b0100011,
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    bcu_none,
    bcu_beq,
    bcu_bne,
    bcu_blt,
    bcu_bge,
    bcu_bltu,
    bcu_bgeu
  } bcu_op_e;

  typedef enum logic [3:0] {
    lsu_none,
    lsu_lb,
    lsu_lh,
    lsu_lw,
    lsu_lbu,
    lsu_lhu,
    lsu_sb,
    lsu_sh,
    lsu_sw
  } lsu_op_e;

  typedef enum logic [1:0] {
    ec_none,
    ec_instr_misaligned,
    ec_load_misaligned,
    ec_store_misaligned
  } ecause_e;

  // one entry, one request in flight.
  typedef enum logic [1:0] {
    pf_idle,
    pf_wait_resp,
    pf_full,
    pf_drop
  } pf_state_e;

endpackage

/* src/prefetch_buffer.sv */
`timescale 1ns/10ps

module prefetch_buffer (
  input  logic        clk,
  input  logic        rst,
  input  logic [31:0] npc,
  input  logic        flush,
  input  logic        take,
  input  logic        mem_ready,
  input  logic [31:0] mem_rdata,
  output logic        mem_valid,
  output logic [31:0] mem_addr,
  output logic [31:0] instr,
  output logic        instr_valid
);

  fetch_pkg::pf_state_e state;
  fetch_pkg::pf_state_e state_nxt;
  logic [31:0] req_addr;
  logic [31:0] word;
  logic        xfer;
  logic        start;

  assign xfer = mem_valid && mem_ready;

  always_comb begin
    state_nxt = state;
    case (state)
      fetch_pkg::pf_idle: state_nxt = fetch_pkg::pf_wait_resp;
      fetch_pkg::pf_wait_resp: begin
        if (flush) begin
          state_nxt = xfer ? fetch_pkg::pf_wait_resp : fetch_pkg::pf_drop;
        end else if (xfer) begin
          state_nxt = fetch_pkg::pf_full;
        end
      end
      fetch_pkg::pf_full: begin
        if (flush || take) state_nxt = fetch_pkg::pf_wait_resp;
      end
      fetch_pkg::pf_drop: begin
        if (xfer) state_nxt = fetch_pkg::pf_wait_resp; // stale word swallowed.
      end
      default: state_nxt = fetch_pkg::pf_idle;
    endcase
  end

  // a new request starts unless the current one is still pending.
  assign start = (state_nxt == fetch_pkg::pf_wait_resp) &&
                 !(state == fetch_pkg::pf_wait_resp && !xfer);

  always_ff @(posedge clk) begin
    if (!rst) begin
      state <= fetch_pkg::pf_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (start) req_addr <= npc;
    if (state == fetch_pkg::pf_wait_resp && xfer && !flush) word <= mem_rdata;
  end

  assign mem_valid = (state == fetch_pkg::pf_wait_resp) || (state == fetch_pkg::pf_drop);
  assign mem_addr = req_addr;
  assign instr = word;
  assign instr_valid = (state == fetch_pkg::pf_full);

  a_req_hold: assert property (@(posedge clk) disable iff (!rst)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr))
    else $error("imem request dropped or address changed while pending.");

  // the buffer only fills from a live response, never out of idle or drop.
  a_fill_src: assert property (@(posedge clk) disable iff (!rst)
    $rose(instr_valid) |-> $past(xfer) && $past(state) == fetch_pkg::pf_wait_resp)
    else $error("buffer filled without an accepted response.");

endmodule

/* src/predecoder.sv */
`timescale 1ns/10ps

module predecoder (
  input  logic                 [31:0] instr,
  output logic                 [31:0] imm,
  output logic                 [4:0]  waddr,
  output logic                 [4:0]  raddr1,
  output logic                 [4:0]  raddr2,
  output logic                        wren,
  output logic                        rden1,
  output logic                        rden2,
  output logic                        lui,
  output logic                        auipc,
  output logic                        jal,
  output logic                        jalr,
  output logic                        branch,
  output logic                        load,
  output logic                        store,
  output fetch_pkg::bcu_op_e          bcu_op,
  output fetch_pkg::lsu_op_e          lsu_op,
  output logic                        valid
);

  fetch_pkg::opcode_e opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  assign opcode = fetch_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign waddr = instr[11:7];
  assign raddr1 = instr[19:15];
  assign raddr2 = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    imm = '0;
    wren = 1'b0;
    rden1 = 1'b0;
    rden2 = 1'b0;
    lui = 1'b0;
    auipc = 1'b0;
    jal = 1'b0;
    jalr = 1'b0;
    branch = 1'b0;
    load = 1'b0;
    store = 1'b0;
    bcu_op = fetch_pkg::bcu_none;
    lsu_op = fetch_pkg::lsu_none;
    valid = 1'b1;
    case (opcode)
      fetch_pkg::opc_lui: begin
        imm = imm_u;
        wren = 1'b1;
        lui = 1'b1;
      end
      fetch_pkg::opc_auipc: begin
        imm = imm_u;
        wren = 1'b1;
        auipc = 1'b1;
      end
      fetch_pkg::opc_jal: begin
        imm = imm_j;
        wren = 1'b1;
        jal = 1'b1;
      end
      fetch_pkg::opc_jalr: begin
        imm = imm_i;
        wren = 1'b1;
        rden1 = 1'b1;
        jalr = 1'b1;
        valid = (funct3 == 3'b000);
      end
      fetch_pkg::opc_branch: begin
        imm = imm_b;
        rden1 = 1'b1;
        rden2 = 1'b1;
        branch = 1'b1;
        case (funct3)
          3'b000: bcu_op = fetch_pkg::bcu_beq;
          3'b001: bcu_op = fetch_pkg::bcu_bne;
          3'b100: bcu_op = fetch_pkg::bcu_blt;
          3'b101: bcu_op = fetch_pkg::bcu_bge;
          3'b110: bcu_op = fetch_pkg::bcu_bltu;
          3'b111: bcu_op = fetch_pkg::bcu_bgeu;
          default: valid = 1'b0;
        endcase
      end
      fetch_pkg::opc_load: begin
        imm = imm_i;
        wren = 1'b1;
        rden1 = 1'b1;
        load = 1'b1;
        case (funct3)
          3'b000: lsu_op = fetch_pkg::lsu_lb;
          3'b001: lsu_op = fetch_pkg::lsu_lh;
          3'b010: lsu_op = fetch_pkg::lsu_lw;
          3'b100: lsu_op = fetch_pkg::lsu_lbu;
          3'b101: lsu_op = fetch_pkg::lsu_lhu;
          default: valid = 1'b0;
        endcase
      end
      fetch_pkg::opc_store: begin
        imm = imm_s;
        rden1 = 1'b1;
        rden2 = 1'b1;
        store = 1'b1;
        case (funct3)
          3'b000: lsu_op = fetch_pkg::lsu_sb;
          3'b001: lsu_op = fetch_pkg::lsu_sh;
          3'b010: lsu_op = fetch_pkg::lsu_sw;
          default: valid = 1'b0;
        endcase
      end
      fetch_pkg::opc_op_imm: begin
        imm = imm_i;
        wren = 1'b1;
        rden1 = 1'b1;
        if (funct3 == 3'b001) valid = (funct7 == 7'b0000000); // slli.
        if (funct3 == 3'b101) valid = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
      end
      fetch_pkg::opc_op: begin
        wren = 1'b1;
        rden1 = 1'b1;
        rden2 = 1'b1;
        valid = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      default: valid = 1'b0;
    endcase

    // unknown encoding issues nothing.
    if (!valid) begin
      imm = '0;
      wren = 1'b0;
      rden1 = 1'b0;
      rden2 = 1'b0;
      lui = 1'b0;
      auipc = 1'b0;
      jal = 1'b0;
      jalr = 1'b0;
      branch = 1'b0;
      load = 1'b0;
      store = 1'b0;
      bcu_op = fetch_pkg::bcu_none;
      lsu_op = fetch_pkg::lsu_none;
    end
  end

endmodule

/* src/register_file.sv */
`timescale 1ns/10ps

module register_file (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  raddr1,
  input  logic [4:0]  raddr2,
  output logic [31:0] rdata1,
  output logic [31:0] rdata2,
  input  logic        wren,
  input  logic [4:0]  waddr,
  input  logic [31:0] wdata
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wren && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // write-back in the same cycle wins over the array.
  assign rdata1 = (raddr1 == 5'd0) ? '0 : (wren && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == 5'd0) ? '0 : (wren && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

/* src/branch_compare_unit.sv */
`timescale 1ns/10ps

module branch_compare_unit (
  input  logic               [31:0] rdata1,
  input  logic               [31:0] rdata2,
  input  fetch_pkg::bcu_op_e        bcu_op,
  output logic                      taken
);

  logic eq;
  logic lt;
  logic ltu;

  assign eq = (rdata1 == rdata2);
  assign lt = ($signed(rdata1) < $signed(rdata2));
  assign ltu = (rdata1 < rdata2);

  always_comb begin
    case (bcu_op)
      fetch_pkg::bcu_beq:  taken = eq;
      fetch_pkg::bcu_bne:  taken = !eq;
      fetch_pkg::bcu_blt:  taken = lt;
      fetch_pkg::bcu_bge:  taken = !lt;
      fetch_pkg::bcu_bltu: taken = ltu;
      fetch_pkg::bcu_bgeu: taken = !ltu;
      default:             taken = 1'b0;
    endcase
  end

endmodule

/* src/address_gen_unit.sv */
`timescale 1ns/10ps

module address_gen_unit (
  input  logic               [31:0] pc,
  input  logic               [31:0] rdata1,
  input  logic               [31:0] imm,
  input  logic                      jal,
  input  logic                      jalr,
  input  logic                      branch,
  input  logic                      load,
  input  logic                      store,
  input  fetch_pkg::lsu_op_e        lsu_op,
  output logic               [31:0] address,
  output logic               [3:0]  byteenable,
  output logic                      exception,
  output fetch_pkg::ecause_e        ecause
);

  logic [31:0] sum;
  logic        half;
  logic        word;
  logic        misaligned;

  assign sum = ((jal || branch) ? pc : rdata1) + imm;
  assign address = jalr ? {sum[31:1], 1'b0} : sum;

  assign half = (lsu_op == fetch_pkg::lsu_lh) || (lsu_op == fetch_pkg::lsu_lhu) ||
                (lsu_op == fetch_pkg::lsu_sh);
  assign word = (lsu_op == fetch_pkg::lsu_lw) || (lsu_op == fetch_pkg::lsu_sw);
  assign misaligned = (half && address[0]) || (word && address[1:0] != 2'b00);

  always_comb begin
    case (lsu_op)
      fetch_pkg::lsu_lb, fetch_pkg::lsu_lbu, fetch_pkg::lsu_sb:
        byteenable = 4'b0001 << address[1:0];
      fetch_pkg::lsu_lh, fetch_pkg::lsu_lhu, fetch_pkg::lsu_sh:
        byteenable = 4'b0011 << address[1:0];
      fetch_pkg::lsu_lw, fetch_pkg::lsu_sw:
        byteenable = 4'b1111;
      default:
        byteenable = 4'b0000;
    endcase
  end

  always_comb begin
    exception = 1'b0;
    ecause = fetch_pkg::ec_none;
    if ((jal || jalr || branch) && address[1]) begin
      exception = 1'b1;
      ecause = fetch_pkg::ec_instr_misaligned; // word targets only.
    end else if (load && misaligned) begin
      exception = 1'b1;
      ecause = fetch_pkg::ec_load_misaligned;
    end else if (store && misaligned) begin
      exception = 1'b1;
      ecause = fetch_pkg::ec_store_misaligned;
    end
  end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/10ps

module fetch_stage (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      imem_valid,
  output logic               [31:0] imem_addr,
  input  logic                      imem_ready,
  input  logic               [31:0] imem_rdata,
  input  logic                      redirect,
  input  logic               [31:0] redirect_addr,
  input  logic                      ex_stall,
  input  logic                      wb_wren,
  input  logic               [4:0]  wb_waddr,
  input  logic               [31:0] wb_wdata,
  output logic                      dmem_valid,
  output logic               [31:0] dmem_addr,
  output logic               [31:0] dmem_wdata,
  output logic               [3:0]  dmem_wstrb,
  output logic                      q_valid,
  output logic               [31:0] q_pc,
  output logic               [31:0] q_instr,
  output logic               [31:0] q_imm,
  output logic               [4:0]  q_waddr,
  output logic                      q_wren,
  output logic               [31:0] q_rdata1,
  output logic               [31:0] q_rdata2,
  output logic                      q_load,
  output logic                      q_store,
  output logic                      q_jump,
  output logic               [31:0] q_address,
  output logic               [3:0]  q_byteenable,
  output fetch_pkg::bcu_op_e        q_bcu_op,
  output fetch_pkg::lsu_op_e        q_lsu_op,
  output logic                      q_exception,
  output fetch_pkg::ecause_e        q_ecause
);

  logic [fetch_pkg::xlen-1:0] pc;
  logic [fetch_pkg::xlen-1:0] npc;
  logic [fetch_pkg::xlen-1:0] buf_instr;
  logic [fetch_pkg::xlen-1:0] instr;
  logic                       buf_valid;
  logic                       take;
  logic [31:0]                imm;
  logic [4:0]                 waddr;
  logic [4:0]                 raddr1;
  logic [4:0]                 raddr2;
  logic                       wren;
  logic                       jal;
  logic                       jalr;
  logic                       branch;
  logic                       load;
  logic                       store;
  logic                       dec_valid;
  fetch_pkg::bcu_op_e         bcu_op;
  fetch_pkg::lsu_op_e         lsu_op;
  logic [31:0]                rdata1;
  logic [31:0]                rdata2;
  logic                       taken;
  logic [31:0]                address;
  logic [3:0]                 byteenable;
  logic                       agu_exc;
  fetch_pkg::ecause_e         agu_ecause;
  logic                       wren_ok;
  logic                       load_ok;
  logic                       store_ok;
  logic                       jump_ok;
  logic                       exc_ok;
  fetch_pkg::ecause_e         ecause_ok;
  logic                       q_en;

  assign take = buf_valid && !ex_stall && !redirect;
  assign instr = take ? buf_instr : fetch_pkg::nop; // bubble when nothing issues.

  always_comb begin
    if (redirect) begin
      npc = redirect_addr;
    end else if (take) begin
      npc = pc + 32'd4;
    end else begin
      npc = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      pc <= fetch_pkg::reset_pc;
    end else begin
      pc <= npc;
    end
  end

  prefetch_buffer i_prefetch_buffer (
    .clk(clk), .rst(rst), .npc(npc), .flush(redirect), .take(take),
    .mem_ready(imem_ready), .mem_rdata(imem_rdata), .mem_valid(imem_valid),
    .mem_addr(imem_addr), .instr(buf_instr), .instr_valid(buf_valid)
  );

  predecoder i_predecoder (
    .instr(instr), .imm(imm), .waddr(waddr), .raddr1(raddr1), .raddr2(raddr2),
    .wren(wren), .rden1(), .rden2(), .lui(), .auipc(), .jal(jal), .jalr(jalr),
    .branch(branch), .load(load), .store(store), .bcu_op(bcu_op), .lsu_op(lsu_op),
    .valid(dec_valid)
  );

  register_file i_register_file (
    .clk(clk), .rst(rst), .raddr1(raddr1), .raddr2(raddr2), .rdata1(rdata1),
    .rdata2(rdata2), .wren(wb_wren), .waddr(wb_waddr), .wdata(wb_wdata)
  );

  branch_compare_unit i_branch_compare_unit (
    .rdata1(rdata1), .rdata2(rdata2), .bcu_op(bcu_op), .taken(taken)
  );

  address_gen_unit i_address_gen_unit (
    .pc(pc), .rdata1(rdata1), .imm(imm), .jal(jal), .jalr(jalr), .branch(branch),
    .load(load), .store(store), .lsu_op(lsu_op), .address(address),
    .byteenable(byteenable), .exception(agu_exc), .ecause(agu_ecause)
  );

  // a fault kills the offending operation and its write.
  always_comb begin
    wren_ok = wren;
    load_ok = load;
    store_ok = store;
    jump_ok = jal || jalr || taken;
    exc_ok = agu_exc;
    ecause_ok = agu_ecause;
    if (agu_exc) begin
      if (load) begin
        load_ok = 1'b0;
        wren_ok = 1'b0;
      end else if (store) begin
        store_ok = 1'b0;
      end else if (jump_ok) begin
        jump_ok = 1'b0;
        wren_ok = 1'b0;
      end else begin
        exc_ok = 1'b0; // untaken branch, target never used.
        ecause_ok = fetch_pkg::ec_none;
      end
    end
  end

  always_comb begin
    case (lsu_op)
      fetch_pkg::lsu_sb: dmem_wdata = {4{rdata2[7:0]}};
      fetch_pkg::lsu_sh: dmem_wdata = {2{rdata2[15:0]}};
      default:           dmem_wdata = rdata2;
    endcase
  end

  assign dmem_valid = load_ok || store_ok;
  assign dmem_addr = address;
  assign dmem_wstrb = store_ok ? byteenable : 4'b0000;

  assign q_en = !ex_stall || redirect;

  always_ff @(posedge clk) begin
    if (!rst) begin
      q_valid <= 1'b0;
      q_wren <= 1'b0;
      q_load <= 1'b0;
      q_store <= 1'b0;
      q_jump <= 1'b0;
      q_exception <= 1'b0;
    end else if (q_en) begin
      q_valid <= take && dec_valid;
      q_wren <= wren_ok;
      q_load <= load_ok;
      q_store <= store_ok;
      q_jump <= jump_ok;
      q_exception <= exc_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (q_en) begin
      q_pc <= pc;
      q_instr <= instr;
      q_imm <= imm;
      q_waddr <= waddr;
      q_rdata1 <= rdata1;
      q_rdata2 <= rdata2;
      q_address <= address;
      q_byteenable <= byteenable;
      q_bcu_op <= bcu_op;
      q_lsu_op <= lsu_op;
      q_ecause <= ecause_ok;
    end
  end

  // an access sent to memory is never reported as faulting downstream.
  a_dmem_no_fault: assert property (@(posedge clk) disable iff (!rst)
    dmem_valid |=> !q_exception)
    else $error("dmem access issued for a faulting instruction.");

endmodule

/* src/front_end_top.sv */
`timescale 1ns/10ps

module front_end_top (
  input  logic                      clk,
  input  logic                      rst,
  output logic                      imem_valid,
  output logic               [31:0] imem_addr,
  input  logic                      imem_ready,
  input  logic               [31:0] imem_rdata,
  input  logic                      redirect,
  input  logic               [31:0] redirect_addr,
  input  logic                      ex_stall,
  input  logic                      wb_wren,
  input  logic               [4:0]  wb_waddr,
  input  logic               [31:0] wb_wdata,
  output logic                      dmem_valid,
  output logic               [31:0] dmem_addr,
  output logic               [31:0] dmem_wdata,
  output logic               [3:0]  dmem_wstrb,
  output logic                      q_valid,
  output logic               [31:0] q_pc,
  output logic               [31:0] q_instr,
  output logic               [31:0] q_imm,
  output logic               [4:0]  q_waddr,
  output logic                      q_wren,
  output logic               [31:0] q_rdata1,
  output logic               [31:0] q_rdata2,
  output logic                      q_load,
  output logic                      q_store,
  output logic                      q_jump,
  output logic               [31:0] q_address,
  output logic               [3:0]  q_byteenable,
  output fetch_pkg::bcu_op_e        q_bcu_op,
  output fetch_pkg::lsu_op_e        q_lsu_op,
  output logic                      q_exception,
  output fetch_pkg::ecause_e        q_ecause
);

  fetch_stage i_fetch_stage (.*); // core-facing boundary.

endmodule

/* sim/front_end_model.svh */
`ifndef FRONT_END_MODEL_SVH
`define FRONT_END_MODEL_SVH

logic [31:0] exp_imm;
logic [31:0] exp_address;
logic [31:0] exp_wdata;
logic [4:0]  exp_waddr;
logic        exp_wren;
logic        exp_load;
logic        exp_store;
logic        exp_jump;
logic        exp_exc;
logic [3:0]  exp_be;
fetch_pkg::bcu_op_e exp_bcu;
fetch_pkg::lsu_op_e exp_lsu;
fetch_pkg::ecause_e exp_ecause;

// reference decode of one word, with operands a and b as read in the decode cycle.
task automatic predict_bundle(input logic [31:0] w, input logic [31:0] pc,
                              input logic [31:0] a, input logic [31:0] b);
  logic [2:0]  f3;
  logic        jal;
  logic        jalr;
  logic        branch;
  logic        taken;
  logic        misal;
  logic [31:0] base;
  int          width;
  f3 = w[14:12];
  jal = 0;
  jalr = 0;
  branch = 0;
  taken = 0;
  width = 0;
  exp_imm = 0;
  exp_waddr = w[11:7];
  exp_wren = 0;
  exp_load = 0;
  exp_store = 0;
  exp_bcu = fetch_pkg::bcu_none;
  exp_lsu = fetch_pkg::lsu_none;
  case (w[6:0])
    7'h37, 7'h17: begin
      exp_imm = {w[31:12], 12'h000};
      exp_wren = 1;
    end
    7'h6f: begin
      exp_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      exp_wren = 1;
      jal = 1;
    end
    7'h67: begin
      exp_imm = {{20{w[31]}}, w[31:20]};
      exp_wren = 1;
      jalr = 1;
    end
    7'h63: begin
      exp_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      branch = 1;
      case (f3)
        3'd0: begin exp_bcu = fetch_pkg::bcu_beq;  taken = (a == b); end
        3'd1: begin exp_bcu = fetch_pkg::bcu_bne;  taken = (a != b); end
        3'd4: begin exp_bcu = fetch_pkg::bcu_blt;  taken = ($signed(a) < $signed(b)); end
        3'd5: begin exp_bcu = fetch_pkg::bcu_bge;  taken = ($signed(a) >= $signed(b)); end
        3'd6: begin exp_bcu = fetch_pkg::bcu_bltu; taken = (a < b); end
        default: begin exp_bcu = fetch_pkg::bcu_bgeu; taken = (a >= b); end
      endcase
    end
    7'h03: begin
      exp_imm = {{20{w[31]}}, w[31:20]};
      exp_wren = 1;
      exp_load = 1;
      case (f3)
        3'd0: begin exp_lsu = fetch_pkg::lsu_lb;  width = 1; end
        3'd1: begin exp_lsu = fetch_pkg::lsu_lh;  width = 2; end
        3'd2: begin exp_lsu = fetch_pkg::lsu_lw;  width = 4; end
        3'd4: begin exp_lsu = fetch_pkg::lsu_lbu; width = 1; end
        default: begin exp_lsu = fetch_pkg::lsu_lhu; width = 2; end
      endcase
    end
    7'h23: begin
      exp_imm = {{20{w[31]}}, w[31:25], w[11:7]};
      exp_store = 1;
      case (f3)
        3'd0: begin exp_lsu = fetch_pkg::lsu_sb; width = 1; end
        3'd1: begin exp_lsu = fetch_pkg::lsu_sh; width = 2; end
        default: begin exp_lsu = fetch_pkg::lsu_sw; width = 4; end
      endcase
    end
    7'h13: begin
      exp_imm = {{20{w[31]}}, w[31:20]};
      exp_wren = 1;
    end
    default: exp_wren = 1; // register-register op.
  endcase

  base = (jal || branch) ? pc : a;
  exp_address = base + exp_imm;
  if (jalr) exp_address[0] = 1'b0;
  case (width)
    1: exp_be = 4'b0001 << exp_address[1:0];
    2: exp_be = (exp_address[1:0] == 2'd0) ? 4'b0011 :
                (exp_address[1:0] == 2'd1) ? 4'b0110 :
                (exp_address[1:0] == 2'd2) ? 4'b1100 : 4'b1000;
    4: exp_be = 4'b1111;
    default: exp_be = 4'b0000;
  endcase
  misal = (width == 2 && exp_address[0]) || (width == 4 && exp_address[1:0] != 2'd0);
  exp_wdata = (width == 1) ? {4{b[7:0]}} : (width == 2) ? {2{b[15:0]}} : b;

  exp_jump = jal || jalr || (branch && taken);
  exp_exc = 0;
  exp_ecause = fetch_pkg::ec_none;
  if (exp_jump && exp_address[1]) begin
    exp_exc = 1;
    exp_ecause = fetch_pkg::ec_instr_misaligned;
    exp_jump = 0;
    exp_wren = 0;
  end else if (exp_load && misal) begin
    exp_exc = 1;
    exp_ecause = fetch_pkg::ec_load_misaligned;
    exp_load = 0;
    exp_wren = 0;
  end else if (exp_store && misal) begin
    exp_exc = 1;
    exp_ecause = fetch_pkg::ec_store_misaligned;
    exp_store = 0;
  end
endtask

`endif

/* sim/front_end_tb.sv */
`timescale 1ns/10ps

module front_end_tb;

  localparam int total_instr = 300;
  localparam int first_phase = 150; // bundles before redirects start.
  localparam int cycle_limit = 8 * total_instr + 200;

  logic        clk;
  logic        rst;
  logic        imem_valid;
  logic [31:0] imem_addr;
  logic        imem_ready;
  logic [31:0] imem_rdata;
  logic        redirect;
  logic [31:0] redirect_addr;
  logic        ex_stall;
  logic        wb_wren;
  logic [4:0]  wb_waddr;
  logic [31:0] wb_wdata;
  logic        dmem_valid;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [3:0]  dmem_wstrb;
  logic        q_valid;
  logic [31:0] q_pc;
  logic [31:0] q_instr;
  logic [31:0] q_imm;
  logic [4:0]  q_waddr;
  logic        q_wren;
  logic [31:0] q_rdata1;
  logic [31:0] q_rdata2;
  logic        q_load;
  logic        q_store;
  logic        q_jump;
  logic [31:0] q_address;
  logic [3:0]  q_byteenable;
  fetch_pkg::bcu_op_e q_bcu_op;
  fetch_pkg::lsu_op_e q_lsu_op;
  logic        q_exception;
  fetch_pkg::ecause_e q_ecause;

  logic [31:0] imem [1024];
  logic [31:0] shadow [32];
  logic [31:0] snap [32];
  logic        dv_s;
  logic [31:0] da_s;
  logic [31:0] dw_s;
  logic [3:0]  ds_s;
  logic        valid_s;
  logic [31:0] addr_s;
  logic        stall_prev;
  logic        redirect_prev;
  logic        redirects_on;
  logic        after_redirect;
  logic        first_req_seen;
  logic [31:0] expected_pc;
  int          lat;
  int          cycles;
  int          delivered;
  int          chk [6];
  int          err [6];
  string       test_name [6];

  `include "front_end_model.svh"

  front_end_top i_front_end_top (.*);

  always #20 clk = !clk;

  task automatic compare(input int t, input string what, input logic [31:0] got,
                         input logic [31:0] exp);
    chk[t]++;
    if (got !== exp) begin
      err[t]++;
      $display("mismatch at %0t: %s is %h, expected %h (pc %h)", $time, what, got, exp,
               expected_pc);
    end
  endtask

  function automatic logic [31:0] random_word();
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] r;
    rd = $urandom % 8;
    rs1 = $urandom % 8;
    rs2 = $urandom % 8;
    r = $urandom;
    case ($urandom % 9)
      0: return {r[19:0], rd, 7'h37};
      1: return {r[19:0], rd, 7'h17};
      2: return {r[19:0], rd, 7'h6f};
      3: return {r[11:0], rs1, 3'd0, rd, 7'h67};
      4: begin
        f3 = ($urandom % 3 == 0) ? 3'($urandom % 2) : 3'(4 + $urandom % 4);
        return {r[6:0], rs2, rs1, f3, r[11:7], 7'h63};
      end
      5: begin
        f3 = ($urandom % 5 == 4) ? 3'd5 : 3'(($urandom % 4 == 3) ? 4 : $urandom % 3);
        return {r[11:0], rs1, f3, rd, 7'h03};
      end
      6: return {r[6:0], rs2, rs1, 3'($urandom % 3), r[11:7], 7'h23};
      7: begin
        f3 = $urandom % 8;
        if (f3 == 3'd1) r[11:5] = 7'h00;
        if (f3 == 3'd5) r[11:5] = r[0] ? 7'h20 : 7'h00;
        return {r[11:0], rs1, f3, rd, 7'h13};
      end
      default: begin
        f3 = $urandom % 8;
        r[6:0] = ((f3 == 3'd0 || f3 == 3'd5) && r[7]) ? 7'h20 : 7'h00;
        return {r[6:0], rs2, rs1, f3, rd, 7'h33};
      end
    endcase
  endfunction

  function automatic logic [31:0] random_data();
    case ($urandom % 3)
      0: return $urandom % 4; // small values make branches interesting.
      1: return $urandom & 32'hffff_fffc;
      default: return $urandom;
    endcase
  endfunction

  task automatic check_bundle();
    logic [31:0] w;
    w = imem[expected_pc[11:2]];
    predict_bundle(w, expected_pc, snap[w[19:15]], snap[w[24:20]]);
    compare(after_redirect ? 5 : 0, "q_pc", q_pc, expected_pc);
    compare(0, "q_instr", q_instr, w);
    compare(1, "q_imm", q_imm, exp_imm);
    compare(1, "q_waddr", q_waddr, exp_waddr);
    compare(1, "q_wren", q_wren, exp_wren);
    compare(1, "q_load", q_load, exp_load);
    compare(1, "q_store", q_store, exp_store);
    compare(1, "q_bcu_op", 32'(q_bcu_op), 32'(exp_bcu));
    compare(1, "q_lsu_op", 32'(q_lsu_op), 32'(exp_lsu));
    compare(2, "q_rdata1", q_rdata1, snap[w[19:15]]);
    compare(2, "q_rdata2", q_rdata2, snap[w[24:20]]);
    compare(3, "q_jump", q_jump, exp_jump);
    compare(4, "q_address", q_address, exp_address);
    compare(4, "q_byteenable", q_byteenable, exp_be);
    compare(4, "q_exception", q_exception, exp_exc);
    compare(4, "q_ecause", 32'(q_ecause), 32'(exp_ecause));
    compare(4, "dmem_valid", dv_s, exp_load || exp_store);
    if (exp_load || exp_store) begin
      compare(4, "dmem_addr", da_s, exp_address);
      compare(4, "dmem_wstrb", ds_s, exp_store ? exp_be : 4'b0000);
    end
    if (exp_store) compare(4, "dmem_wdata", dw_s, exp_wdata);
    expected_pc = expected_pc + 32'd4;
    after_redirect = 0;
    delivered++;
  endtask

  // run-time random draws come from this one block.
  always @(posedge clk) begin
    if (!rst) begin
      ex_stall <= 0;
      redirect <= 0;
      wb_wren <= 0;
      imem_ready <= 0;
      lat = $urandom % 4;
    end else begin
      ex_stall <= ($urandom % 5 == 0);
      wb_wren <= $urandom % 2;
      wb_waddr <= $urandom % 8;
      wb_wdata <= random_data();
      if (redirects_on && $urandom % 16 == 0) begin
        redirect <= 1;
        redirect_addr <= ($urandom % 512) * 4;
      end else begin
        redirect <= 0;
      end
      if (imem_ready && valid_s) begin
        imem_ready <= 0;
        lat = $urandom % 4;
      end else if (valid_s) begin
        if (lat == 0) begin
          imem_ready <= 1;
          imem_rdata <= imem[addr_s[11:2]];
        end else begin
          lat--;
        end
      end
    end
  end

  // outputs are sampled mid-cycle.
  always @(negedge clk) begin
    valid_s = imem_valid;
    addr_s = imem_addr;
    if (rst) begin
      cycles++;
      if (imem_valid && !first_req_seen) begin
        first_req_seen = 1;
        compare(0, "first imem_addr", imem_addr, fetch_pkg::reset_pc);
      end
      if (imem_valid && imem_addr >= 32'd4096) begin
        err[0]++;
        $display("fetch at %h runs past the instruction memory", imem_addr);
      end
      if (q_valid && (!stall_prev || redirect_prev)) check_bundle();
      if (wb_wren && wb_waddr != 5'd0) shadow[wb_waddr] = wb_wdata;
      for (int i = 0; i < 32; i++) begin
        snap[i] = shadow[i];
      end
      dv_s = dmem_valid;
      da_s = dmem_addr;
      dw_s = dmem_wdata;
      ds_s = dmem_wstrb;
      stall_prev = ex_stall;
      redirect_prev = redirect;
      if (redirect) begin
        expected_pc = redirect_addr;
        after_redirect = 1;
      end
    end
  end

  initial begin
    wait (cycles > cycle_limit);
    $display("timeout: only %0d of %0d bundles after %0d cycles", delivered,
             total_instr, cycles);
    $display("Done: errors found");
    $finish;
  end

  initial begin
    int errors;
    int checks;
    void'($urandom(32'h7dcdb66f));
    test_name[0] = "sequential fetch";
    test_name[1] = "decode";
    test_name[2] = "register read and bypass";
    test_name[3] = "branch and jump";
    test_name[4] = "address and faults";
    test_name[5] = "redirect";
    for (int i = 0; i < 6; i++) begin
      chk[i] = 0;
      err[i] = 0;
    end
    for (int i = 0; i < 1024; i++) begin
      imem[i] = random_word();
    end
    for (int i = 0; i < 32; i++) begin
      shadow[i] = 0;
    end
    clk = 0;
    rst = 0;
    redirect = 0;
    redirect_addr = 0;
    ex_stall = 0;
    wb_wren = 0;
    wb_waddr = 0;
    wb_wdata = 0;
    imem_ready = 0;
    imem_rdata = 0;
    redirects_on = 0;
    after_redirect = 0;
    first_req_seen = 0;
    stall_prev = 0;
    redirect_prev = 0;
    expected_pc = fetch_pkg::reset_pc;
    cycles = 0;
    delivered = 0;
    repeat (4) @(negedge clk);
    compare(0, "reset imem_valid", imem_valid, 0);
    compare(0, "reset q_valid", q_valid, 0);
    compare(4, "reset dmem_valid", dmem_valid, 0);
    compare(4, "reset q_load", q_load, 0);
    compare(4, "reset q_store", q_store, 0);
    compare(3, "reset q_jump", q_jump, 0);
    compare(4, "reset q_exception", q_exception, 0);
    @(posedge clk);
    rst <= 1;
    wait (delivered >= first_phase);
    redirects_on = 1;
    wait (delivered >= total_instr);
    errors = 0;
    checks = 0;
    for (int i = 0; i < 6; i++) begin
      $display("test %0d %s: %0d checks, %0d errors", i + 1, test_name[i], chk[i], err[i]);
      errors += err[i];
      checks += chk[i];
    end
    $display("total: %0d bundles, %0d checks, %0d errors", delivered, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
src/fetch_pkg.sv
src/prefetch_buffer.sv
src/predecoder.sv
src/register_file.sv
src/branch_compare_unit.sv
src/address_gen_unit.sv
src/fetch_stage.sv
src/front_end_top.sv
sim/front_end_tb.sv

/* Bender.yml */
package:
  name: front_end

sources:
  - src/fetch_pkg.sv
  - src/prefetch_buffer.sv
  - src/predecoder.sv
  - src/register_file.sv
  - src/branch_compare_unit.sv
  - src/address_gen_unit.sv
  - src/fetch_stage.sv
  - src/front_end_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/front_end_tb.sv
